// ==== slot_cfg.svh ====
// step divider, raster timing, strip geometry and reel speed profile thresholds
`ifndef SLOT_CFG_SVH
`define SLOT_CFG_SVH

// clocks per reel step, kept short for simulation
`define SLOT_STEP_DIV 4
`define SLOT_SPIN_LEN 1000

`define SLOT_STRIP_ROWS 240
`define SLOT_STRIP_COLS 320
`define SLOT_SYMBOL_ROWS 40
`define SLOT_BAND_A_END 110
`define SLOT_BAND_C_START 210

// 640x480 raster, counted in pixel enables
`define SLOT_H_ACTIVE 640
`define SLOT_H_FRONT 16
`define SLOT_H_SYNC 96
`define SLOT_H_TOTAL 800
`define SLOT_V_ACTIVE 480
`define SLOT_V_FRONT 10
`define SLOT_V_SYNC 2
`define SLOT_V_TOTAL 525

// slow to mid window shared by all reels, reel a drops back to slow at its end
`define SLOT_MID_START 239
`define SLOT_MID_END 359
`define SLOT_A_STOP 599
`define SLOT_B_FAST_START 359
`define SLOT_B_FAST_END 439
`define SLOT_B_SLOW_AT 559
`define SLOT_B_STOP 799
`define SLOT_C_FAST_START 359
`define SLOT_C_FAST_END 599
`define SLOT_C_SLOW_AT 719
`define SLOT_C_STOP 959

`endif

// ==== slot_pkg.sv ====
// slot_pkg: row, column, strip address, color, step and speed types, reel state enum
package slot_pkg;

	// strip row, 0 to 239
	typedef logic [7:0] row_t;

	// raster coordinate, full or halved
	typedef logic [9:0] col_t;

	// row * 320 + column
	typedef logic [16:0] strip_addr_t;

	// 4 bits each of red, green, blue
	typedef logic [11:0] rgb_t;

	// step within one spin
	typedef logic [9:0] step_cnt_t;

	// rows moved per step
	typedef logic [1:0] speed_t;

	// encoding is the speed in rows per step
	typedef enum logic [1:0] {
		REEL_STOP = 2'd0,
		REEL_SLOW = 2'd1,
		REEL_MID  = 2'd2,
		REEL_FAST = 2'd3
	} reel_state_e;

endpackage

// ==== button_cond.sv ====
// button_cond: four-sample debounce and single step pulse for one button
`timescale 1ns/100ps

module button_cond (
	input  logic clk,
	input  logic reset,
	input  logic step_en_i,
	input  logic btn_i,
	output logic pulse_o
);

	logic [3:0] samples;
	logic       level;
	logic       level_d;

	// stable only after four high samples
	assign level = &samples;

	always_ff @(posedge clk) begin
		if (reset) begin
			samples <= '0;
			level_d <= 1'b0;
			pulse_o <= 1'b0;
		end else if (step_en_i) begin
			samples <= {samples[2:0], btn_i};
			level_d <= level;
			// held for one full step, so one step_en sees it
			pulse_o <= level & ~level_d;
		end
	end

endmodule

// ==== reel_control.sv ====
// reel_control: spin counter, reel speed FSMs, direction and wrapping reel positions
`timescale 1ns/100ps
`include "slot_cfg.svh"

module reel_control (
	input  logic           clk,
	input  logic           reset,
	input  logic           step_en_i,
	input  logic           up_i,
	input  logic           down_i,
	output slot_pkg::row_t pos_a_o,
	output slot_pkg::row_t pos_b_o,
	output slot_pkg::row_t pos_c_o,
	output logic           busy_o
);
	import slot_pkg::*;

	step_cnt_t   step_cnt;
	reel_state_e state_a;
	reel_state_e state_b;
	reel_state_e state_c;
	reel_state_e state_a_nx;
	reel_state_e state_b_nx;
	reel_state_e state_c_nx;
	logic        dir_up;
	logic        all_stopped;
	logic        accept;
	logic        spin_end;

	// speed profile of a running reel, stop handled by the caller
	function automatic reel_state_e next_state(input reel_state_e st, input step_cnt_t cnt,
			input step_cnt_t stop_at, input step_cnt_t slow_at,
			input step_cnt_t fast_start, input step_cnt_t fast_end);
		reel_state_e nx;
		nx = st;
		case (st)
			REEL_SLOW: begin
				if (cnt >= stop_at)
					nx = REEL_STOP;
				else if (cnt >= step_cnt_t'(`SLOT_MID_START) && cnt < step_cnt_t'(`SLOT_MID_END))
					nx = REEL_MID;
			end
			REEL_MID: begin
				if (cnt >= slow_at)
					nx = REEL_SLOW;
				else if (cnt >= fast_start && cnt < fast_end)
					nx = REEL_FAST;
			end
			REEL_FAST: begin
				if (cnt >= fast_end)
					nx = REEL_MID;
			end
			default: nx = REEL_STOP;
		endcase
		return nx;
	endfunction

	// one step of travel, modulo the strip height
	function automatic row_t wrap_step(input row_t pos, input speed_t spd, input logic up);
		logic [8:0] sum;
		row_t       res;
		if (up) begin
			sum = {1'b0, pos} + {7'd0, spd};
			if (sum >= 9'(`SLOT_STRIP_ROWS))
				sum = sum - 9'(`SLOT_STRIP_ROWS);
			res = sum[7:0];
		end else if (pos < {6'd0, spd}) begin
			res = pos + row_t'(`SLOT_STRIP_ROWS) - {6'd0, spd};
		end else begin
			res = pos - {6'd0, spd};
		end
		return res;
	endfunction

	assign all_stopped = (state_a == REEL_STOP) && (state_b == REEL_STOP) &&
		(state_c == REEL_STOP);
	assign accept = all_stopped && (step_cnt == '0) && !busy_o && (up_i || down_i);
	assign spin_end = (step_cnt == step_cnt_t'(`SLOT_SPIN_LEN));

	// reel a passes its mid end as an empty fast window, so it never goes fast
	assign state_a_nx = accept ? REEL_SLOW : next_state(state_a, step_cnt,
		step_cnt_t'(`SLOT_A_STOP), step_cnt_t'(`SLOT_MID_END),
		step_cnt_t'(`SLOT_MID_END), step_cnt_t'(`SLOT_MID_END));
	assign state_b_nx = accept ? REEL_SLOW : next_state(state_b, step_cnt,
		step_cnt_t'(`SLOT_B_STOP), step_cnt_t'(`SLOT_B_SLOW_AT),
		step_cnt_t'(`SLOT_B_FAST_START), step_cnt_t'(`SLOT_B_FAST_END));
	assign state_c_nx = accept ? REEL_SLOW : next_state(state_c, step_cnt,
		step_cnt_t'(`SLOT_C_STOP), step_cnt_t'(`SLOT_C_SLOW_AT),
		step_cnt_t'(`SLOT_C_FAST_START), step_cnt_t'(`SLOT_C_FAST_END));

	always_ff @(posedge clk) begin
		if (reset) begin
			step_cnt <= '0;
			state_a <= REEL_STOP;
			state_b <= REEL_STOP;
			state_c <= REEL_STOP;
		end else if (step_en_i) begin
			if (spin_end) begin
				step_cnt <= '0;
				state_a <= REEL_STOP;
				state_b <= REEL_STOP;
				state_c <= REEL_STOP;
			end else begin
				if (accept || step_cnt != '0)
					step_cnt <= step_cnt + 1'b1;
				state_a <= state_a_nx;
				state_b <= state_b_nx;
				state_c <= state_c_nx;
			end
		end
	end

	// busy also covers the settle step after the clear, 1001 steps in all
	always_ff @(posedge clk) begin
		if (reset) begin
			busy_o <= 1'b0;
			dir_up <= 1'b0;
		end else if (step_en_i) begin
			if (accept) begin
				busy_o <= 1'b1;
				dir_up <= up_i;
			end else if (step_cnt == '0) begin
				busy_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos_a_o <= '0;
			pos_b_o <= '0;
			pos_c_o <= '0;
		end else if (step_en_i) begin
			pos_a_o <= wrap_step(pos_a_o, speed_t'(state_a), dir_up);
			pos_b_o <= wrap_step(pos_b_o, speed_t'(state_b), dir_up);
			pos_c_o <= wrap_step(pos_c_o, speed_t'(state_c), dir_up);
		end
	end

endmodule

// ==== vga_timing.sv ====
// vga_timing: 640x480 pixel and line counters, sync pulses and active flag
`timescale 1ns/100ps
`include "slot_cfg.svh"

module vga_timing (
	input  logic           clk,
	input  logic           reset,
	input  logic           pix_en_i,
	output slot_pkg::col_t h_cnt_o,
	output slot_pkg::col_t v_cnt_o,
	output logic           hsync_o,
	output logic           vsync_o,
	output logic           active_o
);
	import slot_pkg::*;

	col_t pix_cnt;
	col_t line_cnt;
	col_t pix_nx;
	col_t line_nx;
	logic h_end;
	logic v_end;

	assign h_end = (pix_cnt == col_t'(`SLOT_H_TOTAL - 1));
	assign v_end = (line_cnt == col_t'(`SLOT_V_TOTAL - 1));
	assign pix_nx = h_end ? '0 : pix_cnt + 1'b1;
	assign line_nx = !h_end ? line_cnt : (v_end ? '0 : line_cnt + 1'b1);

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt <= '0;
			line_cnt <= '0;
		end else if (pix_en_i) begin
			pix_cnt <= pix_nx;
			line_cnt <= line_nx;
		end
	end

	// syncs decoded from the next count so they line up with the counters
	always_ff @(posedge clk) begin
		if (reset) begin
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
		end else if (pix_en_i) begin
			hsync_o <= !(pix_nx >= col_t'(`SLOT_H_ACTIVE + `SLOT_H_FRONT) &&
				pix_nx < col_t'(`SLOT_H_ACTIVE + `SLOT_H_FRONT + `SLOT_H_SYNC));
			vsync_o <= !(line_nx >= col_t'(`SLOT_V_ACTIVE + `SLOT_V_FRONT) &&
				line_nx < col_t'(`SLOT_V_ACTIVE + `SLOT_V_FRONT + `SLOT_V_SYNC));
		end
	end

	assign active_o = (pix_cnt < col_t'(`SLOT_H_ACTIVE)) && (line_cnt < col_t'(`SLOT_V_ACTIVE));
	assign h_cnt_o = (pix_cnt < col_t'(`SLOT_H_ACTIVE)) ? pix_cnt : '0;
	assign v_cnt_o = (line_cnt < col_t'(`SLOT_V_ACTIVE)) ? line_cnt : '0;

endmodule

// ==== strip_addr_gen.sv ====
// strip_addr_gen: reel band select and scrolled strip address
`timescale 1ns/100ps
`include "slot_cfg.svh"

module strip_addr_gen (
	input  slot_pkg::col_t        h_half_i,
	input  slot_pkg::col_t        v_half_i,
	input  slot_pkg::row_t        pos_a_i,
	input  slot_pkg::row_t        pos_b_i,
	input  slot_pkg::row_t        pos_c_i,
	output slot_pkg::strip_addr_t addr_o
);
	import slot_pkg::*;

	row_t sel_pos;
	col_t row_sum;
	col_t row_wrap;

	// three column bands, one per reel
	always_comb begin
		if (h_half_i < col_t'(`SLOT_BAND_A_END))
			sel_pos = pos_a_i;
		else if (h_half_i > col_t'(`SLOT_BAND_C_START))
			sel_pos = pos_c_i;
		else
			sel_pos = pos_b_i;
	end

	// scroll against the reel position
	assign row_sum = v_half_i + (col_t'(`SLOT_STRIP_ROWS - 1) - {2'b00, sel_pos});

	// wrap at 239, the last strip row shows only without scroll
	assign row_wrap = (row_sum >= col_t'(`SLOT_STRIP_ROWS - 1)) ?
		row_sum - col_t'(`SLOT_STRIP_ROWS - 1) : row_sum;

	assign addr_o = strip_addr_t'(row_wrap) * strip_addr_t'(`SLOT_STRIP_COLS) +
		strip_addr_t'(h_half_i);

endmodule

// ==== reel_strip_rom.sv ====
// reel_strip_rom: computed symbol strip image with registered color output
`timescale 1ns/100ps
`include "slot_cfg.svh"

module reel_strip_rom (
	input  logic                  clk,
	input  logic                  pix_en_i,
	input  slot_pkg::strip_addr_t addr_i,
	output slot_pkg::rgb_t        rgb_o
);
	import slot_pkg::*;

	strip_addr_t row_full;
	row_t        row;
	row_t        symbol;
	rgb_t        color;

	assign row_full = addr_i / strip_addr_t'(`SLOT_STRIP_COLS);
	assign row = row_t'(row_full);
	assign symbol = row / row_t'(`SLOT_SYMBOL_ROWS);

	always_comb begin
		// black line between symbols
		if (row % row_t'(`SLOT_SYMBOL_ROWS) == '0) begin
			color = '0;
		end else begin
			case (symbol)
				8'd0: color = 12'hf00;
				8'd1: color = 12'hff0;
				8'd2: color = 12'h0f0;
				8'd3: color = 12'h0ff;
				8'd4: color = 12'h00f;
				8'd5: color = 12'hf0f;
				default: color = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pix_en_i)
			rgb_o <= color;
	end

endmodule

// ==== slot_display_top.sv ====
// slot_display_top: enables, buttons, reel control, raster, strip image and blanking
`timescale 1ns/100ps
`include "slot_cfg.svh"

module slot_display_top (
	input  logic           clk,
	input  logic           reset,
	input  logic           spin_up_i,
	input  logic           spin_down_i,
	output logic [3:0]     vga_red_o,
	output logic [3:0]     vga_green_o,
	output logic [3:0]     vga_blue_o,
	output logic           hsync_o,
	output logic           vsync_o,
	output logic           busy_o,
	output slot_pkg::row_t pos_a_o,
	output slot_pkg::row_t pos_b_o,
	output slot_pkg::row_t pos_c_o
);
	import slot_pkg::*;

	localparam int STEP_W = $clog2(`SLOT_STEP_DIV + 1);

	logic              pix_tog;
	logic [STEP_W-1:0] step_div;
	logic              pix_en;
	logic              step_en;
	logic              up_pulse;
	logic              down_pulse;
	col_t              h_cnt;
	col_t              v_cnt;
	col_t              h_half;
	col_t              v_half;
	logic              hsync_raw;
	logic              vsync_raw;
	logic              active_raw;
	logic              active_d;
	strip_addr_t       strip_addr;
	rgb_t              rgb_raw;
	rgb_t              rgb_out;

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_tog <= 1'b0;
			step_div <= '0;
		end else begin
			pix_tog <= ~pix_tog;
			step_div <= step_en ? '0 : step_div + 1'b1;
		end
	end

	assign pix_en = pix_tog;
	assign step_en = (step_div == STEP_W'(`SLOT_STEP_DIV - 1));

	button_cond u_btn_up (
		.clk       (clk),
		.reset     (reset),
		.step_en_i (step_en),
		.btn_i     (spin_up_i),
		.pulse_o   (up_pulse)
	);

	button_cond u_btn_down (
		.clk       (clk),
		.reset     (reset),
		.step_en_i (step_en),
		.btn_i     (spin_down_i),
		.pulse_o   (down_pulse)
	);

	reel_control u_reels (
		.clk       (clk),
		.reset     (reset),
		.step_en_i (step_en),
		.up_i      (up_pulse),
		.down_i    (down_pulse),
		.pos_a_o   (pos_a_o),
		.pos_b_o   (pos_b_o),
		.pos_c_o   (pos_c_o),
		.busy_o    (busy_o)
	);

	vga_timing u_vga (
		.clk      (clk),
		.reset    (reset),
		.pix_en_i (pix_en),
		.h_cnt_o  (h_cnt),
		.v_cnt_o  (v_cnt),
		.hsync_o  (hsync_raw),
		.vsync_o  (vsync_raw),
		.active_o (active_raw)
	);

	// half resolution image
	assign h_half = {1'b0, h_cnt[9:1]};
	assign v_half = {1'b0, v_cnt[9:1]};

	strip_addr_gen u_addr (
		.h_half_i (h_half),
		.v_half_i (v_half),
		.pos_a_i  (pos_a_o),
		.pos_b_i  (pos_b_o),
		.pos_c_i  (pos_c_o),
		.addr_o   (strip_addr)
	);

	reel_strip_rom u_rom (
		.clk      (clk),
		.pix_en_i (pix_en),
		.addr_i   (strip_addr),
		.rgb_o    (rgb_raw)
	);

	// match the one pixel latency of the strip image
	always_ff @(posedge clk) begin
		if (reset) begin
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
			active_d <= 1'b0;
		end else if (pix_en) begin
			hsync_o <= hsync_raw;
			vsync_o <= vsync_raw;
			active_d <= active_raw;
		end
	end

	assign rgb_out = active_d ? rgb_raw : '0;
	assign {vga_red_o, vga_green_o, vga_blue_o} = rgb_out;

endmodule

// ==== slot_display_properties.sv ====
// reel position and raster assertions, bound into reel_control and vga_timing
`timescale 1ns/100ps
`include "slot_cfg.svh"

module slot_display_properties (
	input logic           clk,
	input logic           reset,
	input logic           busy_i,
	input slot_pkg::row_t pos_a_i,
	input slot_pkg::row_t pos_b_i,
	input slot_pkg::row_t pos_c_i,
	input logic           hsync_i,
	input logic           active_i,
	input slot_pkg::col_t h_cnt_i,
	input slot_pkg::col_t v_cnt_i
);
	import slot_pkg::*;

	a_pos_range: assert property (@(posedge clk) disable iff (reset)
		pos_a_i < row_t'(`SLOT_STRIP_ROWS) && pos_b_i < row_t'(`SLOT_STRIP_ROWS) &&
		pos_c_i < row_t'(`SLOT_STRIP_ROWS))
		else $error("reel position outside the strip");

	// reels stand still while no spin runs
	a_pos_hold: assert property (@(posedge clk) disable iff (reset)
		!busy_i |=> $stable(pos_a_i) && $stable(pos_b_i) && $stable(pos_c_i))
		else $error("reel position changed while not busy");

	// raster counts step by one inside the active area
	a_h_step: assert property (@(posedge clk) disable iff (reset)
		(h_cnt_i != $past(h_cnt_i) && h_cnt_i != '0) |-> h_cnt_i == $past(h_cnt_i) + 1'b1)
		else $error("pixel count skipped a value");

	a_v_step: assert property (@(posedge clk) disable iff (reset)
		(v_cnt_i != $past(v_cnt_i) && v_cnt_i != '0) |-> v_cnt_i == $past(v_cnt_i) + 1'b1)
		else $error("line count skipped a value");

	a_hsync_blank: assert property (@(posedge clk) disable iff (reset)
		!hsync_i |-> !active_i)
		else $error("hsync pulse inside the active area");

endmodule

// each instance ties off the ports that belong to the other block
bind reel_control slot_display_properties u_reel_props (
	.clk (clk), .reset (reset), .busy_i (busy_o),
	.pos_a_i (pos_a_o), .pos_b_i (pos_b_o), .pos_c_i (pos_c_o),
	.hsync_i (1'b1), .active_i (1'b0), .h_cnt_i (10'd0), .v_cnt_i (10'd0)
);

bind vga_timing slot_display_properties u_vga_props (
	.clk (clk), .reset (reset), .busy_i (1'b1),
	.pos_a_i (8'd0), .pos_b_i (8'd0), .pos_c_i (8'd0),
	.hsync_i (hsync_o), .active_i (active_o), .h_cnt_i (h_cnt_o), .v_cnt_i (v_cnt_o)
);

// ==== slot_display_tb.sv ====
// file-driven spins, final position, spin length, stop order and frame checks
`timescale 1ns/100ps
`include "slot_cfg.svh"

module slot_display_tb;
	import slot_pkg::*;

	localparam int CLK_NS = 8;
	localparam int SPIN_CLKS = (`SLOT_SPIN_LEN + 1) * `SLOT_STEP_DIV;
	localparam int FRAME_CLKS = 2 * `SLOT_H_TOTAL * `SLOT_V_TOTAL;
	localparam int HS_START = `SLOT_H_ACTIVE + `SLOT_H_FRONT;
	localparam int VS_START = `SLOT_V_ACTIVE + `SLOT_V_FRONT;
	// rows moved in one spin summed over each speed profile
	localparam int DISP_A = `SLOT_MID_START + 2 * (`SLOT_MID_END - `SLOT_MID_START) +
		`SLOT_A_STOP - `SLOT_MID_END;
	localparam int DISP_B = `SLOT_MID_START + 2 * (`SLOT_B_FAST_START - `SLOT_MID_START) +
		3 * (`SLOT_B_FAST_END - `SLOT_B_FAST_START) +
		2 * (`SLOT_B_SLOW_AT - `SLOT_B_FAST_END) + `SLOT_B_STOP - `SLOT_B_SLOW_AT;
	localparam int DISP_C = `SLOT_MID_START + 2 * (`SLOT_C_FAST_START - `SLOT_MID_START) +
		3 * (`SLOT_C_FAST_END - `SLOT_C_FAST_START) +
		2 * (`SLOT_C_SLOW_AT - `SLOT_C_FAST_END) + `SLOT_C_STOP - `SLOT_C_SLOW_AT;
	localparam rgb_t PALETTE [6] = '{12'hf00, 12'hff0, 12'h0f0, 12'h0ff, 12'h00f, 12'hf0f};

	logic       clk;
	logic       reset;
	logic       spin_up;
	logic       spin_down;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;
	logic       hsync;
	logic       vsync;
	logic       busy;
	row_t       pos_a, pos_b, pos_c;
	row_t       prev_a, prev_b, prev_c;
	int         last_a, last_b, last_c;
	int         model_a, model_b, model_c;
	int         errors;
	int         checks;
	int         seed;
	int         busy_clks;
	bit         timer_armed;
	int         code_q[$];
	int         wait_q[$];
	int         exp_a_q[$];
	int         exp_b_q[$];
	int         exp_c_q[$];

	slot_display_top UUT (
		.clk         (clk),
		.reset       (reset),
		.spin_up_i   (spin_up),
		.spin_down_i (spin_down),
		.vga_red_o   (red),
		.vga_green_o (green),
		.vga_blue_o  (blue),
		.hsync_o     (hsync),
		.vsync_o     (vsync),
		.busy_o      (busy),
		.pos_a_o     (pos_a),
		.pos_b_o     (pos_b),
		.pos_c_o     (pos_c)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// spin length in clocks and the last move of each reel
	always @(negedge clk) begin
		if (busy) begin
			busy_clks = busy_clks + 1;
			if (pos_a != prev_a)
				last_a = busy_clks;
			if (pos_b != prev_b)
				last_b = busy_clks;
			if (pos_c != prev_c)
				last_c = busy_clks;
		end
		prev_a = pos_a;
		prev_b = pos_b;
		prev_c = pos_c;
	end

	task automatic check_row(input string what, input row_t got, input row_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_rgb(input string what, input rgb_t got, input rgb_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	function automatic int advance(input int pos, input int disp, input bit up);
		if (up)
			return (pos + disp) % `SLOT_STRIP_ROWS;
		return (pos + `SLOT_STRIP_ROWS - disp % `SLOT_STRIP_ROWS) % `SLOT_STRIP_ROWS;
	endfunction

	function automatic rgb_t expected_pixel(input int x, input int y);
		int pos;
		int row;
		if (x >= `SLOT_H_ACTIVE || y >= `SLOT_V_ACTIVE)
			return '0;
		if (x / 2 < `SLOT_BAND_A_END)
			pos = model_a;
		else if (x / 2 > `SLOT_BAND_C_START)
			pos = model_c;
		else
			pos = model_b;
		// strip scrolls against the reel with one wrap at row 239
		row = y / 2 + `SLOT_STRIP_ROWS - 1 - pos;
		if (row >= `SLOT_STRIP_ROWS - 1)
			row = row - (`SLOT_STRIP_ROWS - 1);
		if (row % `SLOT_SYMBOL_ROWS == 0)
			return '0;
		return PALETTE[row / `SLOT_SYMBOL_ROWS];
	endfunction

	task automatic press(input int which);
		int hold;
		hold = 24 + ($random(seed) & 31);
		if (which == 0)
			spin_up = 1'b1;
		else
			spin_down = 1'b1;
		repeat (hold) @(negedge clk);
		spin_up = 1'b0;
		spin_down = 1'b0;
	endtask

	task automatic wait_busy(input logic level, input int limit, output bit ok);
		int n;
		n = 0;
		while (busy !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		ok = (busy === level);
	endtask

	// one whole frame starting at output pixel (0, 490) where vsync falls
	task automatic check_frame();
		int    x;
		int    y;
		string where;
		while (vsync !== 1'b1)
			@(negedge clk);
		while (vsync !== 1'b0)
			@(negedge clk);
		x = 0;
		y = VS_START;
		repeat (`SLOT_H_TOTAL * `SLOT_V_TOTAL) begin
			where = $sformatf("pixel %0d,%0d", x, y);
			check_rgb(where, {red, green, blue}, expected_pixel(x, y));
			check_bit({where, " hsync"}, hsync, !(x >= HS_START && x < HS_START + `SLOT_H_SYNC));
			check_bit({where, " vsync"}, vsync, !(y >= VS_START && y < VS_START + `SLOT_V_SYNC));
			@(negedge clk);
			@(negedge clk);
			x++;
			if (x == `SLOT_H_TOTAL) begin
				x = 0;
				y = (y + 1) % `SLOT_V_TOTAL;
			end
		end
	endtask

	initial begin
		int    fd;
		int    i;
		int    code;
		int    wait_clks;
		int    ea, eb, ec;
		bit    ok;
		bit    up;
		string header;
		reset = 1'b1;
		spin_up = 1'b0;
		spin_down = 1'b0;
		errors = 0;
		checks = 0;
		seed = 90102;
		busy_clks = 0;
		model_a = 0;
		model_b = 0;
		model_c = 0;
		ok = 1'b1;
		fd = $fopen("spin_input.txt", "r");
		if (fd == 0) begin
			$display("could not open spin_input.txt");
			errors++;
		end else begin
			void'($fgets(header, fd));
			while ($fscanf(fd, "%d %d %d %d %d", code, wait_clks, ea, eb, ec) == 5) begin
				code_q.push_back(code);
				wait_q.push_back(wait_clks);
				exp_a_q.push_back(ea);
				exp_b_q.push_back(eb);
				exp_c_q.push_back(ec);
			end
			$fclose(fd);
		end
		timer_armed = 1'b1;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		check_bit("busy after reset", busy, 1'b0);
		check_bit("hsync after reset", hsync, 1'b1);
		check_bit("vsync after reset", vsync, 1'b1);
		check_rgb("color after reset", {red, green, blue}, '0);
		check_row("reel a after reset", pos_a, '0);
		check_row("reel b after reset", pos_b, '0);
		check_row("reel c after reset", pos_c, '0);
		for (i = 0; i < code_q.size() && ok; i++) begin
			up = (code_q[i] % 2 == 0);
			repeat (wait_q[i]) @(negedge clk);
			busy_clks = 0;
			last_a = 0;
			last_b = 0;
			last_c = 0;
			press(up ? 0 : 1);
			wait_busy(1'b1, 40 * `SLOT_STEP_DIV, ok);
			if (!ok) begin
				$display("busy did not rise after the press of spin %0d", i);
				errors++;
				break;
			end
			// the other button mid-spin is ignored by the reels
			if (code_q[i] >= 2) begin
				repeat (SPIN_CLKS / 2) @(negedge clk);
				press(up ? 1 : 0);
			end
			wait_busy(1'b0, SPIN_CLKS + 100, ok);
			if (!ok) begin
				$display("busy did not fall at the end of spin %0d", i);
				errors++;
				break;
			end
			model_a = advance(model_a, DISP_A, up);
			model_b = advance(model_b, DISP_B, up);
			model_c = advance(model_c, DISP_C, up);
			check_row("reel a final", pos_a, row_t'(exp_a_q[i]));
			check_row("reel b final", pos_b, row_t'(exp_b_q[i]));
			check_row("reel c final", pos_c, row_t'(exp_c_q[i]));
			check_bit("file row matches the displacement rule", exp_a_q[i] == model_a &&
				exp_b_q[i] == model_b && exp_c_q[i] == model_c, 1'b1);
			check_count("busy clocks", busy_clks, SPIN_CLKS);
			check_bit("reels stop in order a, b, c", last_a < last_b && last_b < last_c, 1'b1);
		end
		if (ok)
			check_frame();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// limit grows with the spins read from the file
	initial begin
		wait (timer_armed);
		#(CLK_NS * (code_q.size() * 1100 * `SLOT_STEP_DIV + 2 * FRAME_CLKS));
		$display("watchdog expired, the run took longer than its spins and two frames");
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== spin_input.txt ====
# code (0 up, 1 down, +2 other button pressed mid-spin), wait clocks, final pos a, b, c
0 3 239 239 239
2 40 238 238 238
1 17 239 239 239
1 100 0 0 0
3 9 1 1 1
1 61 2 2 2
1 25 3 3 3
0 5 2 2 2

// ==== src.f ====
+incdir+.
slot_pkg.sv
button_cond.sv
reel_control.sv
vga_timing.sv
strip_addr_gen.sv
reel_strip_rom.sv
slot_display_top.sv
slot_display_properties.sv
slot_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the slot display testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module slot_display_tb \
	&& ./obj_dir/Vslot_display_tb | tee /dev/stderr | grep -x "Test OK" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
